//--- verilog/saturnPkg.sv
`default_nettype none

package saturnPkg;

	localparam int CPU_ADDR_W = 27;
	localparam int MEM_ADDR_W = 25;
	localparam int DATA_W     = 32;
	localparam int BE_W       = 4;
	localparam int WAIT_CNT_W = 8;

	typedef logic [CPU_ADDR_W-1:0] cpuAddr_t;
	typedef logic [MEM_ADDR_W-1:0] memAddr_t;
	typedef logic [DATA_W-1:0]     busData_t;
	typedef logic [BE_W-1:0]       byteEn_t;
	typedef logic [WAIT_CNT_W-1:0] waitCnt_t;

	// Boot hook, offset inside high RAM
	localparam memAddr_t HOOK_ADDR = 25'h12B0;

	localparam cpuAddr_t ROM_BASE  = 27'h0000000;
	localparam cpuAddr_t ROM_SIZE  = 27'h0080000;
	localparam cpuAddr_t SRAM_BASE = 27'h0180000;
	localparam cpuAddr_t SRAM_SIZE = 27'h0010000;
	localparam cpuAddr_t RAML_BASE = 27'h0200000;
	localparam cpuAddr_t RAML_SIZE = 27'h0100000;
	localparam cpuAddr_t RAMH_BASE = 27'h6000000;
	localparam cpuAddr_t RAMH_SIZE = 27'h0100000;

	typedef struct packed {
		logic     valid;
		logic     write;
		cpuAddr_t addr;
		byteEn_t  byteEn;
		busData_t wdata;
	} busReq_t;

	typedef struct packed {
		logic     done;
		busData_t rdata;
	} busRsp_t;

	// All active low
	typedef struct packed {
		logic rom;
		logic sram;
		logic ramLow;
		logic ramHigh;
	} chipSel_t;

	localparam chipSel_t SEL_NONE = '1;

	typedef struct packed {
		memAddr_t addr;
		byteEn_t  byteEnN;
		logic     rdN;
		busData_t wdata;
		chipSel_t sel;
	} memReq_t;

	typedef enum logic {
		MASTER_CPU,
		SLAVE_CPU
	} busId_t;

endpackage

`default_nettype wire

//--- verilog/clockEnable.sv
`default_nettype none

module clockEnable (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic dbgPause,
	input  logic dbgBreak,
	input  logic dbgRun,
	output logic ceR,
	output logic ceF
);

	logic breakFlag;
	logic pause;
	logic mclk;

	// Run wins over a break in the same cycle
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			breakFlag <= 1'b0;
		end else if (dbgRun) begin
			breakFlag <= 1'b0;
		end else if (dbgBreak) begin
			breakFlag <= 1'b1;
		end
	end

	assign pause = dbgPause | breakFlag;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mclk <= 1'b0;
		end else if (ce && !pause) begin
			mclk <= ~mclk;
		end
	end

	assign ceR = mclk & ~pause;
	assign ceF = ~mclk & ~pause;

	enablesExclusive: assert property (@(posedge CLK) disable iff (!RST_N) !(ceR && ceF));

endmodule

`default_nettype wire

//--- verilog/busArbiter.sv
`default_nettype none

module busArbiter
	import saturnPkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     ceR,
	input  busReq_t  mshReq,
	input  busReq_t  sshReq,
	output busRsp_t  mshRsp,
	output busRsp_t  sshRsp,
	output busReq_t  grantReq,
	input  logic     accDone,
	input  busData_t accRdata
);

	busId_t  owner;
	logic    busy;
	busReq_t ownerReq;

	// Master CPU always wins an idle bus
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			owner <= MASTER_CPU;
			busy  <= 1'b0;
		end else if (ceR) begin
			if (!busy) begin
				if (mshReq.valid) begin
					owner <= MASTER_CPU;
					busy  <= 1'b1;
				end else if (sshReq.valid) begin
					owner <= SLAVE_CPU;
					busy  <= 1'b1;
				end
			end else if (accDone) begin
				busy <= 1'b0;
			end
		end
	end

	assign ownerReq = (owner == MASTER_CPU) ? mshReq : sshReq;
	assign grantReq = busy ? ownerReq : '0;

	// Completion goes back to the owner only
	always_comb begin
		mshRsp = '0;
		sshRsp = '0;
		if (busy) begin
			if (owner == MASTER_CPU) begin
				mshRsp.done  = accDone;
				mshRsp.rdata = accRdata;
			end else begin
				sshRsp.done  = accDone;
				sshRsp.rdata = accRdata;
			end
		end
	end

	mshDoneOnRequest: assert property (@(posedge CLK) disable iff (!RST_N)
		mshRsp.done |-> mshReq.valid);

	sshDoneOnRequest: assert property (@(posedge CLK) disable iff (!RST_N)
		sshRsp.done |-> sshReq.valid);

endmodule

`default_nettype wire

//--- verilog/memoryPort.sv
`default_nettype none

module memoryPort
	import saturnPkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     ceR,
	input  busReq_t  grantReq,
	output logic     accDone,
	output busData_t accRdata,
	output memReq_t  memOut,
	input  busData_t memRdata,
	input  logic     memWaitN
);

	chipSel_t decSel;
	logic     decMapped;
	logic     active;
	chipSel_t selQ;
	logic     rdNQ;
	byteEn_t  byteEnNQ;
	memAddr_t addrQ;
	busData_t wdataQ;
	logic     waitN;

	function automatic logic inRegion(cpuAddr_t addr, cpuAddr_t base, cpuAddr_t size);
		return (addr >= base) && ((addr - base) < size);
	endfunction

	always_comb begin
		decSel = SEL_NONE;
		if (inRegion(grantReq.addr, ROM_BASE, ROM_SIZE)) begin
			decSel.rom = 1'b0;
		end else if (inRegion(grantReq.addr, SRAM_BASE, SRAM_SIZE)) begin
			decSel.sram = 1'b0;
		end else if (inRegion(grantReq.addr, RAML_BASE, RAML_SIZE)) begin
			decSel.ramLow = 1'b0;
		end else if (inRegion(grantReq.addr, RAMH_BASE, RAMH_SIZE)) begin
			decSel.ramHigh = 1'b0;
		end
	end

	assign decMapped = (decSel != SEL_NONE);

	// Strobes come up the clock after the grant and drop with the completion
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			active   <= 1'b0;
			selQ     <= SEL_NONE;
			rdNQ     <= 1'b1;
			byteEnNQ <= '1;
		end else if (!active) begin
			if (grantReq.valid) begin
				active   <= 1'b1;
				selQ     <= decSel;
				rdNQ     <= !(decMapped && !grantReq.write);
				byteEnNQ <= (decMapped && grantReq.write) ? ~grantReq.byteEn : '1;
			end
		end else if (accDone) begin
			active   <= 1'b0;
			selQ     <= SEL_NONE;
			rdNQ     <= 1'b1;
			byteEnNQ <= '1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!active && grantReq.valid) begin
			addrQ  <= grantReq.addr[MEM_ADDR_W-1:0];
			wdataQ <= grantReq.wdata;
		end
	end

	// Unmapped access never waits
	assign waitN = memWaitN | (selQ == SEL_NONE);

	assign accDone  = active & ceR & waitN;
	assign accRdata = (selQ == SEL_NONE) ? '1 : memRdata;

	assign memOut = '{addr: addrQ, byteEnN: byteEnNQ, rdN: rdNQ, wdata: wdataQ, sel: selQ};

	oneSelectLow: assert property (@(posedge CLK) disable iff (!RST_N)
		$countones(~memOut.sel) <= 1);

	idleStrobes: assert property (@(posedge CLK) disable iff (!RST_N)
		!active |-> (memOut.sel == SEL_NONE && memOut.rdN && memOut.byteEnN == '1));

endmodule

`default_nettype wire

//--- verilog/debugMonitor.sv
`default_nettype none

module debugMonitor
	import saturnPkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     ceR,
	input  memReq_t  memOut,
	output waitCnt_t dbgWaitCnt,
	output logic     dbgHook
);

	logic busActive;

	assign busActive = !memOut.rdN || (memOut.byteEnN != '1);

	// Counts ceR since the last strobe, wrapping at full scale
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dbgWaitCnt <= '0;
			dbgHook    <= 1'b0;
		end else if (ceR) begin
			if (busActive) begin
				dbgWaitCnt <= '0;
			end else begin
				dbgWaitCnt <= dbgWaitCnt + 1'b1;
			end
			if (!memOut.rdN && !memOut.sel.ramHigh && memOut.addr == HOOK_ADDR) begin
				dbgHook <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/saturnBus.sv
`default_nettype none

module saturnBus
	import saturnPkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     ce,
	input  logic     dbgPause,
	input  logic     dbgBreak,
	input  logic     dbgRun,
	input  busReq_t  mshReq,
	input  busReq_t  sshReq,
	output busRsp_t  mshRsp,
	output busRsp_t  sshRsp,
	output memReq_t  memOut,
	input  busData_t memRdata,
	input  logic     memWaitN,
	output waitCnt_t dbgWaitCnt,
	output logic     dbgHook
);

	logic     ceR;
	busReq_t  grantReq;
	logic     accDone;
	busData_t accRdata;

	// Falling enable has no user on this bus
	clockEnable clockEnable_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ce(ce),
		.dbgPause(dbgPause),
		.dbgBreak(dbgBreak),
		.dbgRun(dbgRun),
		.ceR(ceR),
		.ceF()
	);

	busArbiter busArbiter_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(ceR),
		.mshReq(mshReq),
		.sshReq(sshReq),
		.mshRsp(mshRsp),
		.sshRsp(sshRsp),
		.grantReq(grantReq),
		.accDone(accDone),
		.accRdata(accRdata)
	);

	memoryPort memoryPort_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(ceR),
		.grantReq(grantReq),
		.accDone(accDone),
		.accRdata(accRdata),
		.memOut(memOut),
		.memRdata(memRdata),
		.memWaitN(memWaitN)
	);

	debugMonitor debugMonitor_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(ceR),
		.memOut(memOut),
		.dbgWaitCnt(dbgWaitCnt),
		.dbgHook(dbgHook)
	);

endmodule

`default_nettype wire

//--- sim/extMemModel.sv
`default_nettype none

module extMemModel
	import saturnPkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     ceR,
	input  logic     waitEnable,
	input  memReq_t  memOut,
	output busData_t memRdata,
	output logic     memWaitN,
	output int       strobeCycles
);

	timeunit 1ns;
	timeprecision 100ps;

	// Each region is modeled over its low 16 KB, higher offsets alias
	localparam int WIN_W = 12;
	localparam int STORE_WORDS = 4 << WIN_W;

	busData_t           store [STORE_WORDS];
	logic [1:0]         region;
	logic               mapped;
	logic [WIN_W+1:0]   index;
	logic [1:0]         waitLeft;
	logic [1:0]         nextWait;
	logic [31:0]        randWord;

	function automatic busData_t mergeBytes(busData_t oldWord, busData_t newWord, byteEn_t beN);
		busData_t merged;
		merged = oldWord;
		for (int b = 0; b < BE_W; b++) begin
			if (!beN[b]) begin
				merged[8*b +: 8] = newWord[8*b +: 8];
			end
		end
		return merged;
	endfunction

	always_comb begin
		mapped = 1'b1;
		region = 2'd0;
		if (!memOut.sel.rom) region = 2'd0;
		else if (!memOut.sel.sram) region = 2'd1;
		else if (!memOut.sel.ramLow) region = 2'd2;
		else if (!memOut.sel.ramHigh) region = 2'd3;
		else mapped = 1'b0;
	end

	assign index = {region, memOut.addr[WIN_W+1:2]};
	assign memRdata = mapped ? store[index] : '0;
	assign memWaitN = (waitLeft == 2'd0);

	// Fill depends on every index bit
	initial begin
		for (int i = 0; i < STORE_WORDS; i++) begin
			store[i] = {16'hA5C3 ^ i[15:0], i[15:0]};
		end
	end

	initial begin
		void'($urandom(88016));
		forever begin
			@(posedge CLK);
			randWord = $urandom;
			nextWait <= randWord[1:0];
		end
	end

	// Wait length is drawn while idle, then counted down on ceR
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			waitLeft     <= 2'd0;
			strobeCycles <= 0;
		end else begin
			if (!memOut.rdN || memOut.byteEnN != '1) strobeCycles <= strobeCycles + 1;
			if (!mapped) waitLeft <= waitEnable ? nextWait : 2'd0;
			else if (ceR && waitLeft != 2'd0) waitLeft <= waitLeft - 2'd1;
		end
	end

	always @(posedge CLK) begin
		if (mapped && ceR && memWaitN && memOut.byteEnN != '1) begin
			store[index] <= mergeBytes(store[index], memOut.wdata, memOut.byteEnN);
		end
	end

endmodule

`default_nettype wire

//--- sim/saturnBusTb.sv
`default_nettype none

module saturnBusTb
	import saturnPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_STIM = 14;
	localparam int LIMIT_NS = (2 * N_STIM + 2) * 16 * 80;
	localparam logic [1:0] PORT_M = 2'd0;
	localparam logic [1:0] PORT_S = 2'd1;
	localparam logic [1:0] PORT_BOTH = 2'd2;
	localparam int IDLE_CLOCKS = 20;
	// Running mclk gives a ceR on every second clock
	localparam waitCnt_t IDLE_CER = IDLE_CLOCKS / 2;

	typedef struct packed {
		logic [1:0] port;
		logic       write;
		cpuAddr_t   addr;
		byteEn_t    byteEn;
		busData_t   wdata;
	} stimEntry_t;

	logic       CLK, RST_N, ce, dbgPause, dbgBreak, dbgRun, waitEnable;
	logic       memWaitN, dbgHook;
	busReq_t    mshReq, sshReq;
	busRsp_t    mshRsp, sshRsp;
	memReq_t    memOut;
	busData_t   memRdata;
	waitCnt_t   dbgWaitCnt;
	int         strobeCycles;
	stimEntry_t stimTable [N_STIM];
	string      stimName [N_STIM];
	cpuAddr_t   refAddr [$];
	busData_t   refData [$];
	int         dataErrs, selErrs, countErrs, flagErrs, otherErrs;

	saturnBus dut_i (.*);

	extMemModel extMemModel_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(dut_i.ceR),
		.waitEnable(waitEnable),
		.memOut(memOut),
		.memRdata(memRdata),
		.memWaitN(memWaitN),
		.strobeCycles(strobeCycles)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	initial begin
		#(LIMIT_NS);
		$display("Watchdog expired after %0d ns with accesses still running", LIMIT_NS);
		$display("TEST FAIL");
		$finish;
	end

	task automatic checkData(string name, busData_t expVal, busData_t actVal);
		if (actVal !== expVal) begin
			dataErrs++;
			$display("[FAIL] %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkSel(string name, chipSel_t expVal, chipSel_t actVal);
		if (actVal !== expVal) begin
			selErrs++;
			$display("[FAIL] %s: expected select %b, actual %b", name, expVal, actVal);
		end
	endtask

	task automatic checkCount(string name, waitCnt_t expVal, waitCnt_t actVal);
		if (actVal !== expVal) begin
			countErrs++;
			$display("[FAIL] %s: expected count %0d, actual %0d", name, expVal, actVal);
		end
	endtask

	task automatic checkFlag(string name, logic expVal, logic actVal);
		if (actVal !== expVal) begin
			flagErrs++;
			$display("[FAIL] %s: expected %b, actual %b", name, expVal, actVal);
		end
	endtask

	task automatic reportError(string name, string what);
		otherErrs++;
		$display("Error in %s: %s", name, what);
	endtask

	task automatic setEntry(int idx, string name, logic [1:0] port, logic write,
		cpuAddr_t addr, byteEn_t be, busData_t wdata);
		stimName[idx] = name;
		stimTable[idx] = {port, write, addr, be, wdata};
	endtask

	// Address map taken from the region bases and sizes
	function automatic chipSel_t regionSel(cpuAddr_t addr);
		chipSel_t sel;
		sel = SEL_NONE;
		if (addr >= ROM_BASE && addr < ROM_BASE + ROM_SIZE) sel.rom = 1'b0;
		else if (addr >= SRAM_BASE && addr < SRAM_BASE + SRAM_SIZE) sel.sram = 1'b0;
		else if (addr >= RAML_BASE && addr < RAML_BASE + RAML_SIZE) sel.ramLow = 1'b0;
		else if (addr >= RAMH_BASE && addr < RAMH_BASE + RAMH_SIZE) sel.ramHigh = 1'b0;
		return sel;
	endfunction

	function automatic busData_t refRead(cpuAddr_t addr);
		foreach (refAddr[i]) begin
			if (refAddr[i] == addr) return refData[i];
		end
		return 'x;
	endfunction

	task automatic refWrite(cpuAddr_t addr, byteEn_t be, busData_t wdata);
		busData_t mask;
		int slot;
		mask = '0;
		slot = -1;
		for (int b = 0; b < BE_W; b++) begin
			if (be[b]) mask[8*b +: 8] = 8'hFF;
		end
		foreach (refAddr[i]) begin
			if (refAddr[i] == addr) slot = i;
		end
		if (slot < 0) begin
			refAddr.push_back(addr);
			refData.push_back(wdata & mask);
		end else begin
			refData[slot] = (refData[slot] & ~mask) | (wdata & mask);
		end
	endtask

	function automatic busReq_t makeReq(logic write, cpuAddr_t addr, byteEn_t be, busData_t wdata);
		busReq_t req;
		req.valid = 1'b1;
		req.write = write;
		req.addr = addr;
		req.byteEn = be;
		req.wdata = wdata;
		return req;
	endfunction

	// Holds the request until done; stallClocks > 0 releases pause or break at that clock
	task automatic runAccess(int idx, int stallClocks);
		stimEntry_t s;
		string name;
		chipSel_t expSel;
		busData_t expM, expS;
		logic expRdN;
		logic mPend, sPend, mDone, sDone;
		int cycles, strobesBefore;
		s = stimTable[idx];
		name = stimName[idx];
		expSel = regionSel(s.addr);
		expRdN = s.write || (expSel == SEL_NONE);
		expM = (expSel == SEL_NONE) ? '1 : refRead(s.addr);
		expS = (s.port == PORT_BOTH) ? refRead(s.addr + 27'd4) : expM;
		mPend = (s.port != PORT_S);
		sPend = (s.port != PORT_M);
		strobesBefore = strobeCycles;
		cycles = 0;
		if (mPend) mshReq = makeReq(s.write, s.addr, s.byteEn, s.wdata);
		if (sPend) sshReq = makeReq(s.write, (s.port == PORT_BOTH) ? s.addr + 27'd4 : s.addr,
			s.byteEn, s.wdata);
		while ((mPend || sPend) && cycles < 64 + stallClocks) begin
			@(negedge CLK);
			cycles++;
			mDone = mshRsp.done;
			sDone = sshRsp.done;
			if ((mDone || sDone) && cycles <= stallClocks) reportError(name, "done while paused");
			if ((mDone || sDone) && !memWaitN && memOut.sel != SEL_NONE)
				reportError(name, "done while memory wait was low");
			if (sDone && mPend) reportError(name, "slave CPU finished before master CPU");
			if (mDone || sDone) checkSel(name, expSel, memOut.sel);
			if (mDone || sDone) checkFlag(name, expRdN, memOut.rdN);
			if (mDone && !s.write) checkData(name, expM, mshRsp.rdata);
			if (sDone && !s.write) checkData(name, expS, sshRsp.rdata);
			@(posedge CLK);
			#2;
			if (cycles == stallClocks) dbgPause = 1'b0;
			dbgRun = (cycles == stallClocks);
			if (mDone) mPend = 1'b0;
			if (sDone) sPend = 1'b0;
			if (mDone) mshReq = '0;
			if (sDone) sshReq = '0;
		end
		if (mPend || sPend) reportError(name, "no done within the access time limit");
		mshReq = '0;
		sshReq = '0;
		dbgRun = 1'b0;
		if (s.write) refWrite(s.addr, s.byteEn, s.wdata);
		if (expSel == SEL_NONE && strobeCycles != strobesBefore)
			reportError(name, "unmapped access reached the memory strobes");
	endtask

	initial begin
		RST_N = 1'b0;
		ce = 1'b1;
		dbgPause = 1'b0;
		dbgBreak = 1'b0;
		dbgRun = 1'b0;
		waitEnable = 1'b0;
		mshReq = '0;
		sshReq = '0;
		dataErrs = 0;
		selErrs = 0;
		countErrs = 0;
		flagErrs = 0;
		otherErrs = 0;
		setEntry(0, "romWrFull", PORT_M, 1'b1, ROM_BASE + 27'h100, 4'hF, 32'h11223344);
		setEntry(1, "romWrMix", PORT_S, 1'b1, ROM_BASE + 27'h100, 4'h5, 32'hAABBCCDD);
		setEntry(2, "romRead", PORT_M, 1'b0, ROM_BASE + 27'h100, 4'hF, '0);
		setEntry(3, "sramWrFull", PORT_S, 1'b1, SRAM_BASE + 27'h40, 4'hF, 32'h55667788);
		setEntry(4, "sramWrMix", PORT_M, 1'b1, SRAM_BASE + 27'h40, 4'hC, 32'h99AA0000);
		setEntry(5, "sramRead", PORT_S, 1'b0, SRAM_BASE + 27'h40, 4'hF, '0);
		setEntry(6, "ramLowWrA", PORT_M, 1'b1, RAML_BASE + 27'h800, 4'hF, 32'h01020304);
		setEntry(7, "ramLowWrB", PORT_S, 1'b1, RAML_BASE + 27'h804, 4'hF, 32'h0A0B0C0D);
		setEntry(8, "ramLowWrMix", PORT_M, 1'b1, RAML_BASE + 27'h804, 4'h2, 32'h0000EE00);
		setEntry(9, "ramHighWrFull", PORT_M, 1'b1, RAMH_BASE + HOOK_ADDR, 4'hF, 32'hCAFEF00D);
		setEntry(10, "ramHighWrMix", PORT_S, 1'b1, RAMH_BASE + HOOK_ADDR, 4'h9, 32'h12000034);
		setEntry(11, "unmappedRead", PORT_M, 1'b0, 27'h4000000, 4'hF, '0);
		setEntry(12, "bothRead", PORT_BOTH, 1'b0, RAML_BASE + 27'h800, 4'hF, '0);
		setEntry(13, "hookRead", PORT_S, 1'b0, RAMH_BASE + HOOK_ADDR, 4'hF, '0);
		repeat (2) @(posedge CLK);
		#2;
		RST_N = 1'b1;
		checkSel("resetSel", SEL_NONE, memOut.sel);
		checkCount("resetCount", '0, dbgWaitCnt);
		checkFlag("resetHook", 1'b0, dbgHook);
		// Second pass replays the table with random memory wait
		for (int pass = 0; pass < 2; pass++) begin
			waitEnable = (pass == 1);
			for (int i = 0; i < N_STIM; i++) runAccess(i, 0);
		end
		checkFlag("hookSet", 1'b1, dbgHook);
		dbgPause = 1'b1;
		runAccess(2, 8);
		dbgBreak = 1'b1;
		@(posedge CLK);
		#2;
		dbgBreak = 1'b0;
		runAccess(5, 8);
		repeat (IDLE_CLOCKS) @(posedge CLK);
		#2;
		checkCount("idleCount", IDLE_CER, dbgWaitCnt);
		$display("Errors: data %0d, select %0d, count %0d, flag %0d, protocol %0d",
			dataErrs, selErrs, countErrs, flagErrs, otherErrs);
		if (dataErrs + selErrs + countErrs + flagErrs + otherErrs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- saturnBus.f
verilog/saturnPkg.sv
verilog/clockEnable.sv
verilog/busArbiter.sv
verilog/memoryPort.sv
verilog/debugMonitor.sv
verilog/saturnBus.sv
sim/extMemModel.sv
sim/saturnBusTb.sv

//--- Bender.yml
package:
  name: saturnbus

sources:
  - files:
      - verilog/saturnPkg.sv
      - verilog/clockEnable.sv
      - verilog/busArbiter.sv
      - verilog/memoryPort.sv
      - verilog/debugMonitor.sv
      - verilog/saturnBus.sv
  - target: simulation
    files:
      - sim/extMemModel.sv
      - sim/saturnBusTb.sv
